/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_dcache
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := Simulation completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* hw/cache_bus_pkg.sv */
// request and response bundles for the processor and memory ports of the data cache
`default_nettype none

package cache_bus_pkg;

	import cache_geom_pkg::*;

	// ------------------------------
	// processor side
	// ------------------------------
	// read and write are levels, at most one high
	typedef struct packed {
		logic       read;
		logic       write;
		word_addr_t addr;
		word_t      wdata;
	} proc_req_t;

	// ------------------------------
	// memory side
	// ------------------------------
	// strobes stay high until the cache has seen ready
	typedef struct packed {
		logic       read;
		logic       write;
		line_addr_t addr;
		line_t      wdata;
	} mem_req_t;

	// ready is a single cycle pulse, rdata valid with it on reads
	typedef struct packed {
		logic  ready;
		line_t rdata;
	} mem_resp_t;

endpackage

`default_nettype wire

/* hw/cache_geom_pkg.sv */
// data cache geometry, address field types and controller states; import into any cache RTL
`default_nettype none

package cache_geom_pkg;

	// ------------------------------
	// geometry
	// ------------------------------
	localparam int num_sets       = 4;
	localparam int words_per_line = 4;

	// processor side is word addressed
	typedef logic [29:0] word_addr_t;
	typedef logic [31:0] word_t;

	// memory side moves whole lines
	typedef logic [27:0]                      line_addr_t;
	typedef word_t [words_per_line-1:0]       line_t;

	// word address = {tag, set, offset}
	typedef logic [$clog2(num_sets)-1:0]       set_idx_t;
	typedef logic [$clog2(words_per_line)-1:0] word_off_t;
	typedef logic [25:0]                       tag_t;

	// ------------------------------
	// controller
	// ------------------------------
	typedef enum logic [1:0] {
		idle,
		compare,
		write_back,
		allocate
	} cache_state_e;

endpackage

`default_nettype wire

/* hw/dcache_ctrl.sv */
// data cache controller FSM; drives stall, memory strobes and the update commands to the store
`default_nettype none

module dcache_ctrl
	import cache_geom_pkg::*;
(
	input  logic         clk,
	input  logic         proc_reset,
	input  logic         proc_read,
	input  logic         proc_write,
	input  logic         mem_ready,
	input  logic         hit,
	input  logic         both_dirty,
	output cache_state_e state,
	output logic         proc_stall,
	output logic         mem_read,
	output logic         mem_write,
	output logic         fill,
	output logic         wb_done,
	output logic         write_hit_en
);

	cache_state_e next_state;
	logic         mem_ready_q;
	logic         req;

	assign req = proc_read | proc_write;

	// ------------------------------
	// state and ready registers
	// ------------------------------
	always_ff @(posedge clk) begin
		if (proc_reset) begin
			state       <= idle;
			mem_ready_q <= 1'b0;
		end else begin
			state       <= next_state;
			mem_ready_q <= mem_ready;
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			idle: begin
				next_state = compare;
			end
			compare: begin
				// both dirty means the LRU line has to go out first
				if (req && !hit) begin
					next_state = both_dirty ? write_back : allocate;
				end
			end
			write_back: begin
				if (mem_ready_q) begin
					next_state = allocate;
				end
			end
			allocate: begin
				if (mem_ready_q) begin
					next_state = compare;
				end
			end
			default: begin
				next_state = idle;
			end
		endcase
	end

	// ------------------------------
	// outputs
	// ------------------------------
	assign proc_stall = req && !(state == compare && hit);

	// strobes drop once the registered ready shows up
	assign mem_read  = (state == allocate) && !mem_ready_q;
	assign mem_write = (state == write_back) && !mem_ready_q;

	assign fill         = (state == allocate) && mem_ready_q;
	assign wb_done      = (state == write_back) && mem_ready_q;
	assign write_hit_en = (state == compare) && hit && proc_write;

endmodule

`default_nettype wire

/* hw/dcache_store.sv */
// tag, state and data arrays of the two-way data cache with hit logic, victim choice and updates
`default_nettype none

module dcache_store
	import cache_geom_pkg::*;
(
	input  logic         clk,
	input  logic         proc_reset,
	input  word_addr_t   proc_addr,
	input  word_t        proc_wdata,
	input  line_t        mem_rdata,
	input  cache_state_e state,
	input  logic         fill,
	input  logic         wb_done,
	input  logic         write_hit_en,
	output logic         hit,
	output logic         both_dirty,
	output word_t        proc_rdata,
	output line_addr_t   mem_addr,
	output line_t        mem_wdata
);

	// ------------------------------
	// storage
	// ------------------------------
	tag_t  tag_q  [2][num_sets];
	line_t data_q [2][num_sets];

	logic [1:0][num_sets-1:0] valid_q;
	logic [1:0][num_sets-1:0] dirty_q;

	// per set, the way to replace next
	logic [num_sets-1:0] lru_q;

	line_t mem_rdata_q;

	// request fields
	tag_t      req_tag;
	set_idx_t  set;
	word_off_t off;

	logic [1:0] way_hit;
	logic       hit_way;
	logic       victim;

	assign req_tag = proc_addr[29:4];
	assign set     = proc_addr[3:2];
	assign off     = proc_addr[1:0];

	// ------------------------------
	// lookup
	// ------------------------------
	always_comb begin
		for (int w = 0; w < 2; w++) begin
			way_hit[w] = valid_q[w][set] && (tag_q[w][set] == req_tag);
		end
	end

	assign hit     = |way_hit;
	assign hit_way = way_hit[1];

	assign both_dirty = dirty_q[0][set] & dirty_q[1][set];

	// a clean way wins, otherwise LRU decides
	always_comb begin
		if (dirty_q[0][set] == dirty_q[1][set]) begin
			victim = lru_q[set];
		end else begin
			victim = dirty_q[0][set];
		end
	end

	assign proc_rdata = hit ? data_q[hit_way][set][off] : '0;

	// victim location during write-back, request line otherwise
	assign mem_addr  = (state == write_back) ? {tag_q[victim][set], set} : proc_addr[29:2];
	assign mem_wdata = data_q[victim][set];

	// ------------------------------
	// updates
	// ------------------------------
	always_ff @(posedge clk) begin
		mem_rdata_q <= mem_rdata;
	end

	always_ff @(posedge clk) begin
		if (proc_reset) begin
			valid_q <= '0;
			dirty_q <= '0;
			lru_q   <= '0;
		end else begin
			if (state == compare && hit) begin
				lru_q[set] <= ~hit_way;
			end
			if (write_hit_en) begin
				dirty_q[hit_way][set] <= 1'b1;
			end
			// written-back line stays valid, now clean
			if (wb_done) begin
				dirty_q[victim][set] <= 1'b0;
			end
			if (fill) begin
				valid_q[victim][set] <= 1'b1;
				dirty_q[victim][set] <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (write_hit_en) begin
			data_q[hit_way][set][off] <= proc_wdata;
		end
		// fill uses the line registered on the ready cycle
		if (fill) begin
			data_q[victim][set] <= mem_rdata_q;
			tag_q[victim][set]  <= req_tag;
		end
	end

endmodule

`default_nettype wire

/* hw/dcache_top.sv */
// data cache top level; connect the processor request port and the slow line memory port here
`default_nettype none

module dcache_top
	import cache_geom_pkg::*;
	import cache_bus_pkg::*;
(
	input  logic      clk,
	input  logic      proc_reset,
	input  proc_req_t proc_req,
	output logic      proc_stall,
	output word_t     proc_rdata,
	output mem_req_t  mem_req,
	input  mem_resp_t mem_resp
);

	cache_state_e state;
	logic         hit;
	logic         both_dirty;
	logic         fill;
	logic         wb_done;
	logic         write_hit_en;
	logic         mem_read;
	logic         mem_write;
	line_addr_t   mem_addr;
	line_t        mem_wdata;

	// ------------------------------
	// memory request assembly
	// ------------------------------
	assign mem_req.read  = mem_read;
	assign mem_req.write = mem_write;
	assign mem_req.addr  = mem_addr;
	assign mem_req.wdata = mem_wdata;

	dcache_ctrl u_ctrl (
		.clk          (clk),
		.proc_reset   (proc_reset),
		.proc_read    (proc_req.read),
		.proc_write   (proc_req.write),
		.mem_ready    (mem_resp.ready),
		.hit          (hit),
		.both_dirty   (both_dirty),
		.state        (state),
		.proc_stall   (proc_stall),
		.mem_read     (mem_read),
		.mem_write    (mem_write),
		.fill         (fill),
		.wb_done      (wb_done),
		.write_hit_en (write_hit_en)
	);

	dcache_store u_store (
		.clk          (clk),
		.proc_reset   (proc_reset),
		.proc_addr    (proc_req.addr),
		.proc_wdata   (proc_req.wdata),
		.mem_rdata    (mem_resp.rdata),
		.state        (state),
		.fill         (fill),
		.wb_done      (wb_done),
		.write_hit_en (write_hit_en),
		.hit          (hit),
		.both_dirty   (both_dirty),
		.proc_rdata   (proc_rdata),
		.mem_addr     (mem_addr),
		.mem_wdata    (mem_wdata)
	);

endmodule

`default_nettype wire

/* src.f */
hw/cache_geom_pkg.sv
hw/cache_bus_pkg.sv
hw/dcache_ctrl.sv
hw/dcache_store.sv
hw/dcache_top.sv
verif/tb_slow_mem.sv
verif/tb_dcache.sv

/* verif/tb_dcache.sv */
// testbench for the data cache; directed and random accesses checked against a word model
`default_nettype none

module tb_dcache
	import cache_geom_pkg::*;
	import cache_bus_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int reset_cycles = 16;
	localparam int cycle_limit  = 40 * 16 * 3 + reset_cycles;
	localparam int kind_hit     = 0;
	localparam int kind_miss    = 1;
	localparam int kind_wb      = 2;
	localparam int kind_any     = 3;

	logic       clk;
	logic       proc_reset;
	proc_req_t  proc_req;
	logic       proc_stall;
	word_t      proc_rdata;
	mem_req_t   mem_req;
	mem_resp_t  mem_resp;

	word_t      model [word_addr_t];
	word_t      exp_word;
	line_addr_t exp_wb_addr;
	line_t      exp_wb_line;
	logic       idle_check;
	logic       wb_check;
	int         value_errors = 0;
	int         protocol_errors = 0;
	int         cycles = 0;
	int         seed;

	dcache_top DUT (.*);

	tb_slow_mem u_mem (.*);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("timeout after %0d cycles, a request never finished", cycles);
			$display("Simulation failed");
			$finish;
		end
	end

	// ------------------------------
	// checks
	// ------------------------------
	assert property (@(posedge clk) disable iff (proc_reset)
		!(mem_req.read && mem_req.write))
	else begin
		protocol_errors++;
		$display("memory read and write strobes are high in the same cycle");
	end

	assert property (@(posedge clk) disable iff (proc_reset)
		idle_check |-> !mem_req.read && !mem_req.write && !proc_stall)
	else begin
		value_errors++;
		$display("FAIL idle: mem_req.read=%h mem_req.write=%h proc_stall=%h, expected 0",
			$sampled(mem_req.read), $sampled(mem_req.write), $sampled(proc_stall));
	end

	assert property (@(posedge clk) disable iff (proc_reset)
		proc_req.read && !proc_stall |-> proc_rdata == exp_word)
	else begin
		value_errors++;
		$display("FAIL proc_rdata=%h expected %h", $sampled(proc_rdata), $sampled(exp_word));
	end

	assert property (@(posedge clk) disable iff (proc_reset)
		mem_req.read |-> mem_req.addr == proc_req.addr[29:2])
	else begin
		value_errors++;
		$display("FAIL mem_req.addr=%h expected %h on read",
			$sampled(mem_req.addr), $sampled(proc_req.addr[29:2]));
	end

	assert property (@(posedge clk) disable iff (proc_reset)
		wb_check && mem_req.write |-> mem_req.addr == exp_wb_addr)
	else begin
		value_errors++;
		$display("FAIL mem_req.addr=%h expected %h on write-back",
			$sampled(mem_req.addr), $sampled(exp_wb_addr));
	end

	assert property (@(posedge clk) disable iff (proc_reset)
		wb_check && mem_req.write |-> mem_req.wdata == exp_wb_line)
	else begin
		value_errors++;
		$display("FAIL mem_req.wdata=%h expected %h",
			$sampled(mem_req.wdata), $sampled(exp_wb_line));
	end

	// ------------------------------
	// reference model and stimulus
	// ------------------------------
	function automatic word_t expected_word(input word_addr_t a);
		if (model.exists(a)) begin
			return model[a];
		end
		return {2'b00, a} ^ 32'h5a5a0000;
	endfunction

	function automatic line_t expected_line(input line_addr_t la);
		line_t l;
		for (int i = 0; i < words_per_line; i++) begin
			l[i] = expected_word({la, i[1:0]});
		end
		return l;
	endfunction

	// caller sits on a rising edge; returns on the edge where the request is done
	task automatic cache_access(input logic wr, input word_addr_t a, input word_t d,
		input int kind);
		logic saw_read;
		logic saw_write;
		int   waits;
		saw_read  = 1'b0;
		saw_write = 1'b0;
		waits     = 0;
		proc_req <= '{read: !wr, write: wr, addr: a, wdata: d};
		exp_word <= expected_word(a);
		do begin
			@(posedge clk);
			saw_read  |= mem_req.read;
			saw_write |= mem_req.write;
			waits++;
		end while (proc_stall);
		if (wr) begin
			model[a] = d;
		end
		if (kind == kind_hit) begin
			assert (waits == 1 && !saw_read && !saw_write) else begin
				protocol_errors++;
				$display("access to %h stalled or used memory although its line is cached", a);
			end
		end
		if (kind == kind_miss || kind == kind_wb) begin
			assert (saw_read) else begin
				protocol_errors++;
				$display("miss on %h finished without a memory read", a);
			end
		end
		if (kind == kind_wb) begin
			assert (saw_write) else begin
				protocol_errors++;
				$display("miss on %h with both ways dirty finished without a write-back", a);
			end
		end
	endtask

	task automatic drop_request();
		proc_req <= '0;
		@(posedge clk);
	endtask

	initial begin
		word_addr_t a;
		tag_t       t;
		set_idx_t   s;
		seed        = 32'hcebb9677;
		proc_reset  = 1'b1;
		proc_req    = '0;
		exp_word    = '0;
		exp_wb_addr = '0;
		exp_wb_line = '0;
		idle_check  = 1'b0;
		wb_check    = 1'b0;
		repeat (reset_cycles) @(posedge clk);
		proc_reset <= 1'b0;

		// quiet ports with no request
		@(posedge clk);
		idle_check <= 1'b1;
		repeat (4) @(posedge clk);
		idle_check <= 1'b0;

		// read miss, then hits in the same line
		t = tag_t'($random(seed));
		s = 2'd1;
		cache_access(1'b0, {t, s, 2'd0}, '0, kind_miss);
		cache_access(1'b0, {t, s, 2'd3}, '0, kind_hit);
		cache_access(1'b1, {t, s, 2'd3}, $random(seed), kind_hit);
		cache_access(1'b0, {t, s, 2'd3}, '0, kind_hit);

		// two dirty lines in set 2, a third tag pushes out the older one
		s = 2'd2;
		cache_access(1'b1, {t, s, 2'd1}, $random(seed), kind_miss);
		cache_access(1'b1, {t ^ 26'd1, s, 2'd2}, $random(seed), kind_miss);
		exp_wb_addr <= {t, s};
		exp_wb_line <= expected_line({t, s});
		wb_check    <= 1'b1;
		cache_access(1'b0, {t ^ 26'd2, s, 2'd0}, '0, kind_wb);
		wb_check    <= 1'b0;

		// random mix of four tags over all sets
		repeat (24) begin
			a = {t ^ 26'($random(seed) & 3), 4'($random(seed))};
			cache_access(1'($random(seed)), a, $random(seed), kind_any);
		end
		drop_request();
		repeat (2) @(posedge clk);

		$display("value errors: %0d, protocol errors: %0d", value_errors, protocol_errors);
		if (value_errors == 0 && protocol_errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* verif/tb_slow_mem.sv */
// slow line memory model for the data cache testbench; random latency, one-cycle ready pulse
`default_nettype none

module tb_slow_mem
	import cache_geom_pkg::*;
	import cache_bus_pkg::*;
(
	input  logic      clk,
	input  logic      proc_reset,
	input  mem_req_t  mem_req,
	output mem_resp_t mem_resp
);

	timeunit 1ns;
	timeprecision 1ps;

	// only lines that were written back are stored
	line_t lines [line_addr_t];
	int    seed;
	int    delay;

	// untouched words hold their own word address with a marker in the upper half
	function automatic line_t line_read(input line_addr_t la);
		line_t l;
		if (lines.exists(la)) begin
			return lines[la];
		end
		for (int i = 0; i < words_per_line; i++) begin
			l[i] = {2'b00, la, i[1:0]} ^ 32'h5a5a0000;
		end
		return l;
	endfunction

	// ------------------------------
	// request handling
	// ------------------------------
	initial begin
		seed     = 32'hcebb9677;
		mem_resp = '0;
		forever begin
			@(posedge clk);
			if (!proc_reset && (mem_req.read || mem_req.write)) begin
				// 1 to 16 cycles until ready
				delay = ($random(seed) & 15) + 1;
				repeat (delay - 1) @(posedge clk);
				if (mem_req.write) begin
					lines[mem_req.addr] = mem_req.wdata;
				end
				mem_resp <= '{ready: 1'b1, rdata: line_read(mem_req.addr)};
				@(posedge clk);
				// strobe is already low again in the following cycle
				mem_resp <= '0;
			end
		end
	end

endmodule

`default_nettype wire
